// File: loongarch_pkg.sv
`default_nettype none

package loongarch_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [13:0] csr_addr_t;
    typedef logic [7:0]  alu_op_t;
    typedef logic [2:0]  alu_sel_t;
    typedef logic [6:0]  exc_code_t;

    localparam alu_op_t ALU_NOP     = 8'h00;
    localparam alu_op_t ALU_ADD     = 8'h01;
    localparam alu_op_t ALU_SUB     = 8'h02;
    localparam alu_op_t ALU_AND     = 8'h03;
    localparam alu_op_t ALU_OR      = 8'h04;
    localparam alu_op_t ALU_LLW     = 8'h10;
    localparam alu_op_t ALU_SCW     = 8'h11;
    localparam alu_op_t ALU_LDW     = 8'h12;
    localparam alu_op_t ALU_STW     = 8'h13;
    localparam alu_op_t ALU_CSRRD   = 8'h20;
    localparam alu_op_t ALU_CSRWR   = 8'h21;
    localparam alu_op_t ALU_CSRXCHG = 8'h22;

    localparam alu_sel_t ALU_SEL_NOP        = 3'd0;
    localparam alu_sel_t ALU_SEL_ARITH      = 3'd1;
    localparam alu_sel_t ALU_SEL_LOGIC      = 3'd2;
    localparam alu_sel_t ALU_SEL_LOAD_STORE = 3'd3;
    localparam alu_sel_t ALU_SEL_CSR        = 3'd4;

    // 2RI14 format, inst[31:24]
    localparam logic [7:0] OPC_LLW = 8'h20;
    localparam logic [7:0] OPC_SCW = 8'h21;
    localparam logic [7:0] OPC_CSR = 8'h04;

    localparam reg_addr_t CSRRD_RJ = 5'd0;  // other rj values give csrxchg
    localparam reg_addr_t CSRWR_RJ = 5'd1;

    // 2RI12 format, inst[31:22]
    localparam logic [9:0] OPC_ADDIW = 10'h00A;
    localparam logic [9:0] OPC_LDW   = 10'h0A2;
    localparam logic [9:0] OPC_STW   = 10'h0A6;

    // 3R format, inst[31:15]
    localparam logic [16:0] OPC_ADDW = 17'h00020;
    localparam logic [16:0] OPC_SUBW = 17'h00022;
    localparam logic [16:0] OPC_AND  = 17'h00029;
    localparam logic [16:0] OPC_OR   = 17'h0002A;

    localparam csr_addr_t CSR_LLBCTL = 14'h060;

    localparam exc_code_t EXC_NONE = 7'h00;
    localparam exc_code_t EXC_ADEF = 7'h08;
    localparam exc_code_t EXC_INE  = 7'h0D;

    typedef struct packed {
        logic      reg_write_en;
        reg_addr_t reg_write_addr;
        logic      reg1_read_en;
        reg_addr_t reg1_read_addr;
        logic      reg2_read_en;
        reg_addr_t reg2_read_addr;
        alu_op_t   aluop;
        alu_sel_t  alusel;
        word_t     imm;
        logic      is_privilege;
        logic      csr_read_en;
        logic      csr_write_en;
        csr_addr_t csr_addr;
    } dec_fields_t;

    typedef struct packed {
        word_t       pc;
        word_t       inst;
        logic        exc;
        exc_code_t   exc_code;
        dec_fields_t fields;
    } id_bundle_t;

    localparam dec_fields_t DEC_NOP = '0;

endpackage

`default_nettype wire

// File: id_2ri14.sv
`timescale 1ns/100ps
`default_nettype none

module id_2ri14 import loongarch_pkg::*; (
    input  word_t       inst,
    output logic        hit,
    output dec_fields_t fields
);

    reg_addr_t   rj;
    reg_addr_t   rd;
    logic [13:0] si14;

    assign rj   = inst[9:5];
    assign rd   = inst[4:0];
    assign si14 = inst[23:10];  // also the csr number for the csr group

    always_comb begin
        hit    = 1'b0;
        fields = DEC_NOP;
        case (inst[31:24])
            OPC_LLW: begin
                hit                   = 1'b1;
                fields.reg_write_en   = 1'b1;
                fields.reg_write_addr = rd;
                fields.reg1_read_en   = 1'b1;
                fields.reg1_read_addr = rj;
                fields.aluop          = ALU_LLW;
                fields.alusel         = ALU_SEL_LOAD_STORE;
                fields.imm            = {{16{si14[13]}}, si14, 2'b00};  // word offset
                fields.csr_read_en    = 1'b1;
                fields.csr_addr       = CSR_LLBCTL;
            end
            OPC_SCW: begin
                hit                   = 1'b1;
                fields.reg_write_en   = 1'b1;
                fields.reg_write_addr = rd;
                fields.reg1_read_en   = 1'b1;
                fields.reg1_read_addr = rj;
                fields.reg2_read_en   = 1'b1;
                fields.reg2_read_addr = rd;  // store data
                fields.aluop          = ALU_SCW;
                fields.alusel         = ALU_SEL_LOAD_STORE;
                fields.csr_read_en    = 1'b1;
                fields.csr_addr       = CSR_LLBCTL;
            end
            OPC_CSR: begin
                hit                   = 1'b1;
                fields.is_privilege   = 1'b1;
                fields.reg_write_en   = 1'b1;
                fields.reg_write_addr = rd;
                fields.alusel         = ALU_SEL_CSR;
                fields.csr_read_en    = 1'b1;
                fields.csr_addr       = si14;
                case (rj)
                    CSRRD_RJ: begin
                        fields.aluop = ALU_CSRRD;
                    end
                    CSRWR_RJ: begin
                        fields.aluop          = ALU_CSRWR;
                        fields.reg1_read_en   = 1'b1;
                        fields.reg1_read_addr = rd;  // new csr value
                        fields.csr_write_en   = 1'b1;
                    end
                    default: begin
                        fields.aluop          = ALU_CSRXCHG;
                        fields.reg1_read_en   = 1'b1;
                        fields.reg1_read_addr = rd;
                        fields.reg2_read_en   = 1'b1;
                        fields.reg2_read_addr = rj;  // write mask
                        fields.csr_write_en   = 1'b1;
                    end
                endcase
            end
            default: begin
                hit    = 1'b0;
                fields = DEC_NOP;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: id_2ri12.sv
`timescale 1ns/100ps
`default_nettype none

module id_2ri12 import loongarch_pkg::*; (
    input  word_t       inst,
    output logic        hit,
    output dec_fields_t fields
);

    reg_addr_t   rj;
    reg_addr_t   rd;
    logic [11:0] si12;

    assign rj   = inst[9:5];
    assign rd   = inst[4:0];
    assign si12 = inst[21:10];

    always_comb begin
        hit    = 1'b0;
        fields = DEC_NOP;
        case (inst[31:22])
            OPC_ADDIW, OPC_LDW: begin
                hit                   = 1'b1;
                fields.reg_write_en   = 1'b1;
                fields.reg_write_addr = rd;
                fields.reg1_read_en   = 1'b1;
                fields.reg1_read_addr = rj;
                fields.imm            = {{20{si12[11]}}, si12};
                if (inst[31:22] == OPC_ADDIW) begin
                    fields.aluop  = ALU_ADD;
                    fields.alusel = ALU_SEL_ARITH;
                end else begin
                    fields.aluop  = ALU_LDW;
                    fields.alusel = ALU_SEL_LOAD_STORE;
                end
            end
            OPC_STW: begin
                hit                   = 1'b1;
                fields.reg1_read_en   = 1'b1;
                fields.reg1_read_addr = rj;  // base
                fields.reg2_read_en   = 1'b1;
                fields.reg2_read_addr = rd;  // store data, no writeback
                fields.aluop          = ALU_STW;
                fields.alusel         = ALU_SEL_LOAD_STORE;
                fields.imm            = {{20{si12[11]}}, si12};
            end
            default: begin
                hit    = 1'b0;
                fields = DEC_NOP;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: id_3r.sv
`timescale 1ns/100ps
`default_nettype none

module id_3r import loongarch_pkg::*; (
    input  word_t       inst,
    output logic        hit,
    output dec_fields_t fields
);

    logic [16:0] opcode;

    assign opcode = inst[31:15];

    always_comb begin
        hit    = 1'b0;
        fields = DEC_NOP;
        if (opcode == OPC_ADDW || opcode == OPC_SUBW ||
            opcode == OPC_AND  || opcode == OPC_OR) begin
            hit                   = 1'b1;
            fields.reg_write_en   = 1'b1;
            fields.reg_write_addr = inst[4:0];
            fields.reg1_read_en   = 1'b1;
            fields.reg1_read_addr = inst[9:5];    // rj
            fields.reg2_read_en   = 1'b1;
            fields.reg2_read_addr = inst[14:10];  // rk
            fields.imm            = '0;
        end
        case (opcode)
            OPC_ADDW: begin
                fields.aluop  = ALU_ADD;
                fields.alusel = ALU_SEL_ARITH;
            end
            OPC_SUBW: begin
                fields.aluop  = ALU_SUB;
                fields.alusel = ALU_SEL_ARITH;
            end
            OPC_AND: begin
                fields.aluop  = ALU_AND;
                fields.alusel = ALU_SEL_LOGIC;
            end
            OPC_OR: begin
                fields.aluop  = ALU_OR;
                fields.alusel = ALU_SEL_LOGIC;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: id_dispatch.sv
`timescale 1ns/100ps
`default_nettype none

module id_dispatch import loongarch_pkg::*; (
    input  word_t      pc,
    input  word_t      inst,
    output id_bundle_t bundle
);

    logic        hit_2ri14;
    logic        hit_2ri12;
    logic        hit_3r;
    logic        any_hit;
    dec_fields_t f_2ri14;
    dec_fields_t f_2ri12;
    dec_fields_t f_3r;
    dec_fields_t sel_fields;

    id_2ri14 u_2ri14 (.inst(inst), .hit(hit_2ri14), .fields(f_2ri14));
    id_2ri12 u_2ri12 (.inst(inst), .hit(hit_2ri12), .fields(f_2ri12));
    id_3r    u_3r    (.inst(inst), .hit(hit_3r),    .fields(f_3r));

    assign any_hit = hit_2ri14 | hit_2ri12 | hit_3r;

    // opcodes are disjoint, at most one term is non-zero
    assign sel_fields = (hit_2ri14 ? f_2ri14 : DEC_NOP) |
                        (hit_2ri12 ? f_2ri12 : DEC_NOP) |
                        (hit_3r    ? f_3r    : DEC_NOP);

    always_comb begin
        bundle.pc   = pc;
        bundle.inst = inst;
        if (pc[1:0] != 2'b00) begin  // fetch fault wins over decode
            bundle.exc      = 1'b1;
            bundle.exc_code = EXC_ADEF;
            bundle.fields   = DEC_NOP;
        end else if (!any_hit) begin
            bundle.exc      = 1'b1;
            bundle.exc_code = EXC_INE;
            bundle.fields   = DEC_NOP;
        end else begin
            bundle.exc      = 1'b0;
            bundle.exc_code = EXC_NONE;
            bundle.fields   = sel_fields;
        end
    end

endmodule

`default_nettype wire

// File: id_stage.sv
`timescale 1ns/100ps
`default_nettype none

module id_stage import loongarch_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       in_valid,
    input  word_t      in_pc,
    input  word_t      in_inst,
    output logic       out_valid,
    output id_bundle_t out_bundle
);

    id_bundle_t dec_bundle;

    id_dispatch u_dispatch (
        .pc     (in_pc),
        .inst   (in_inst),
        .bundle (dec_bundle)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid  <= 1'b0;
            out_bundle <= '0;
        end else begin
            out_valid <= in_valid;  // one pulse per strobe
            if (in_valid) begin
                out_bundle <= dec_bundle;  // held between strobes
            end
        end
    end

    // a decoded legal instruction always carries an operation
    a_legal_has_op: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_bundle.exc |-> out_bundle.fields.aluop != ALU_NOP);

    a_csr_write_priv: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && out_bundle.fields.csr_write_en |-> out_bundle.fields.is_privilege);

    // faulting instruction must not reach writeback
    a_exc_no_write: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && out_bundle.exc |-> !out_bundle.fields.reg_write_en);

endmodule

`default_nettype wire

// File: tb_id_stage.sv
`timescale 1ns/100ps
`default_nettype none

module tb_id_stage import loongarch_pkg::*; ();

    localparam int reps        = 3;  // random instances per opcode
    localparam int test_cycles = 10 + 12 * reps + 40;

    logic       clk;
    logic       arst_n;
    logic       in_valid;
    word_t      in_pc;
    word_t      in_inst;
    logic       out_valid;
    id_bundle_t out_bundle;
    integer     seed;
    int         pass_count;
    int         fail_count;
    logic       bundle_bad;

    id_stage uut (.clk(clk), .arst_n(arst_n), .in_valid(in_valid), .in_pc(in_pc),
                  .in_inst(in_inst), .out_valid(out_valid), .out_bundle(out_bundle));

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #(test_cycles * 4 + 200);
        $display("timeout: the tests did not finish within %0d clock cycles", test_cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    function automatic word_t rand_word();
        word_t r;
        r = $random(seed);
        return r;
    endfunction

    function automatic word_t rand_pc();
        word_t r;
        r = rand_word();
        return {r[31:2], 2'b00};
    endfunction

    // kinds 0..11 are the legal instructions, anything else is unclaimed
    function automatic word_t gen_inst(int kind);
        word_t r;
        r = rand_word();
        case (kind)
            0:  return {OPC_LLW, r[23:0]};
            1:  return {OPC_SCW, r[23:0]};
            2:  return {OPC_CSR, r[23:10], CSRRD_RJ, r[4:0]};
            3:  return {OPC_CSR, r[23:10], CSRWR_RJ, r[4:0]};
            4:  return {OPC_CSR, r[23:10], (r[9:5] < 5'd2) ? r[9:5] + 5'd2 : r[9:5], r[4:0]};
            5:  return {OPC_ADDIW, r[21:0]};
            6:  return {OPC_LDW, r[21:0]};
            7:  return {OPC_STW, r[21:0]};
            8:  return {OPC_ADDW, r[14:0]};
            9:  return {OPC_SUBW, r[14:0]};
            10: return {OPC_AND, r[14:0]};
            11: return {OPC_OR, r[14:0]};
            default: return 32'h0300_0000;
        endcase
    endfunction

    function automatic id_bundle_t model_decode(word_t pc, word_t inst);
        id_bundle_t  b;
        dec_fields_t f;
        logic        legal;
        f     = DEC_NOP;
        legal = 1'b1;
        if (inst[31:24] == OPC_LLW || inst[31:24] == OPC_SCW) begin
            f.reg_write_en   = 1'b1;
            f.reg_write_addr = inst[4:0];
            f.reg1_read_en   = 1'b1;
            f.reg1_read_addr = inst[9:5];
            f.alusel         = ALU_SEL_LOAD_STORE;
            f.csr_read_en    = 1'b1;
            f.csr_addr       = CSR_LLBCTL;
            if (inst[31:24] == OPC_SCW) begin
                f.aluop          = ALU_SCW;
                f.reg2_read_en   = 1'b1;
                f.reg2_read_addr = inst[4:0];
            end else begin
                f.aluop = ALU_LLW;
                f.imm   = {{18{inst[23]}}, inst[23:10]} << 2;
            end
        end else if (inst[31:24] == OPC_CSR) begin
            f.is_privilege   = 1'b1;
            f.reg_write_en   = 1'b1;
            f.reg_write_addr = inst[4:0];
            f.alusel         = ALU_SEL_CSR;
            f.csr_read_en    = 1'b1;
            f.csr_addr       = inst[23:10];
            if (inst[9:5] == CSRRD_RJ) begin
                f.aluop = ALU_CSRRD;
            end else begin
                f.aluop          = (inst[9:5] == CSRWR_RJ) ? ALU_CSRWR : ALU_CSRXCHG;
                f.reg1_read_en   = 1'b1;
                f.reg1_read_addr = inst[4:0];
                f.csr_write_en   = 1'b1;
                if (inst[9:5] != CSRWR_RJ) begin
                    f.reg2_read_en   = 1'b1;
                    f.reg2_read_addr = inst[9:5];  // mask
                end
            end
        end else if (inst[31:22] inside {OPC_ADDIW, OPC_LDW, OPC_STW}) begin
            f.reg1_read_en   = 1'b1;
            f.reg1_read_addr = inst[9:5];
            f.imm            = {{20{inst[21]}}, inst[21:10]};
            if (inst[31:22] == OPC_STW) begin
                f.aluop          = ALU_STW;
                f.alusel         = ALU_SEL_LOAD_STORE;
                f.reg2_read_en   = 1'b1;
                f.reg2_read_addr = inst[4:0];
            end else begin
                f.reg_write_en   = 1'b1;
                f.reg_write_addr = inst[4:0];
                f.aluop  = (inst[31:22] == OPC_ADDIW) ? ALU_ADD : ALU_LDW;
                f.alusel = (inst[31:22] == OPC_ADDIW) ? ALU_SEL_ARITH : ALU_SEL_LOAD_STORE;
            end
        end else if (inst[31:15] inside {OPC_ADDW, OPC_SUBW, OPC_AND, OPC_OR}) begin
            f.reg_write_en   = 1'b1;
            f.reg_write_addr = inst[4:0];
            f.reg1_read_en   = 1'b1;
            f.reg1_read_addr = inst[9:5];
            f.reg2_read_en   = 1'b1;
            f.reg2_read_addr = inst[14:10];
            case (inst[31:15])
                OPC_ADDW: f.aluop = ALU_ADD;
                OPC_SUBW: f.aluop = ALU_SUB;
                OPC_AND:  f.aluop = ALU_AND;
                default:  f.aluop = ALU_OR;
            endcase
            f.alusel = (f.aluop == ALU_AND || f.aluop == ALU_OR) ? ALU_SEL_LOGIC : ALU_SEL_ARITH;
        end else begin
            legal = 1'b0;
        end
        b.pc       = pc;
        b.inst     = inst;
        b.exc      = (pc[1:0] != 2'b00) || !legal;
        b.exc_code = (pc[1:0] != 2'b00) ? EXC_ADEF : (legal ? EXC_NONE : EXC_INE);
        b.fields   = b.exc ? DEC_NOP : f;
        return b;
    endfunction

    task automatic compare_field(string name, string field, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %s.%s got %h exp %h", name, field, got, exp);
            bundle_bad = 1'b1;
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("ERROR %s got %h exp %h", name, got, exp);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic check_bundle(string name, id_bundle_t got, id_bundle_t exp);
        dec_fields_t g;
        dec_fields_t e;
        g          = got.fields;
        e          = exp.fields;
        bundle_bad = 1'b0;
        compare_field(name, "pc", got.pc, exp.pc);
        compare_field(name, "inst", got.inst, exp.inst);
        compare_field(name, "exc", 32'(got.exc), 32'(exp.exc));
        compare_field(name, "exc_code", 32'(got.exc_code), 32'(exp.exc_code));
        compare_field(name, "fields.reg_write_en", 32'(g.reg_write_en), 32'(e.reg_write_en));
        compare_field(name, "fields.reg_write_addr", 32'(g.reg_write_addr), 32'(e.reg_write_addr));
        compare_field(name, "fields.reg1_read_en", 32'(g.reg1_read_en), 32'(e.reg1_read_en));
        compare_field(name, "fields.reg1_read_addr", 32'(g.reg1_read_addr), 32'(e.reg1_read_addr));
        compare_field(name, "fields.reg2_read_en", 32'(g.reg2_read_en), 32'(e.reg2_read_en));
        compare_field(name, "fields.reg2_read_addr", 32'(g.reg2_read_addr), 32'(e.reg2_read_addr));
        compare_field(name, "fields.aluop", 32'(g.aluop), 32'(e.aluop));
        compare_field(name, "fields.alusel", 32'(g.alusel), 32'(e.alusel));
        compare_field(name, "fields.imm", g.imm, e.imm);
        compare_field(name, "fields.is_privilege", 32'(g.is_privilege), 32'(e.is_privilege));
        compare_field(name, "fields.csr_read_en", 32'(g.csr_read_en), 32'(e.csr_read_en));
        compare_field(name, "fields.csr_write_en", 32'(g.csr_write_en), 32'(e.csr_write_en));
        compare_field(name, "fields.csr_addr", 32'(g.csr_addr), 32'(e.csr_addr));
        if (bundle_bad) begin
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    // entered one step after a rising edge, leaves at the same point
    task automatic strobe_and_check(word_t pc, word_t inst);
        in_valid = 1'b1;
        in_pc    = pc;
        in_inst  = inst;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        check_bit("out_valid", out_valid, 1'b1);
        check_bundle("out_bundle", out_bundle, model_decode(pc, inst));
    endtask

    task automatic idle_and_check(int cycles, id_bundle_t held);
        repeat (cycles) begin
            @(posedge clk);
            #1;
            check_bit("out_valid", out_valid, 1'b0);
            check_bundle("out_bundle", out_bundle, held);
        end
    endtask

    task automatic report_test(string name, int fails_before);
        $display("%s finished, %0d failed checks", name, fail_count - fails_before);
    endtask

    task automatic test_reset();
        int fails_before;
        fails_before = fail_count;
        idle_and_check(5, '0);  // arst_n still low
        arst_n = 1'b1;
        idle_and_check(3, '0);
        report_test("reset", fails_before);
    endtask

    task automatic test_2ri14();
        int fails_before;
        fails_before = fail_count;
        for (int kind = 0; kind <= 4; kind++) begin
            repeat (reps) strobe_and_check(rand_pc(), gen_inst(kind));
        end
        strobe_and_check(rand_pc(), gen_inst(0) | 32'h0080_0000);  // negative si14
        report_test("2ri14", fails_before);
    endtask

    task automatic test_2ri12_3r();
        int fails_before;
        fails_before = fail_count;
        for (int kind = 5; kind <= 11; kind++) begin
            repeat (reps) strobe_and_check(rand_pc(), gen_inst(kind));
        end
        strobe_and_check(rand_pc(), gen_inst(6) | 32'h0020_0000);  // negative si12
        report_test("2ri12 and 3r", fails_before);
    endtask

    task automatic test_exceptions();
        int fails_before;
        fails_before = fail_count;
        strobe_and_check(rand_pc(), gen_inst(12));             // INE
        strobe_and_check(rand_pc(), 32'hffff_ffff);
        strobe_and_check(rand_pc() | 32'd1, gen_inst(5));     // ADEF
        strobe_and_check(rand_pc() | 32'd2, gen_inst(12));    // ADEF ahead of INE
        strobe_and_check(rand_pc() | 32'd3, gen_inst(8));
        report_test("exceptions", fails_before);
    endtask

    task automatic test_back_to_back();
        int         fails_before;
        word_t      pc;
        word_t      inst;
        id_bundle_t last;
        fails_before = fail_count;
        for (int i = 0; i < 20; i++) begin
            pc   = rand_pc();
            inst = gen_inst(rand_word() % 12);
            strobe_and_check(pc, inst);
            last = model_decode(pc, inst);
        end
        idle_and_check(3, last);
        pc   = rand_pc();
        inst = gen_inst(rand_word() % 12);
        strobe_and_check(pc, inst);
        idle_and_check(2, model_decode(pc, inst));  // single pulse only
        report_test("back-to-back", fails_before);
    endtask

    initial begin
        seed       = 32'h020ecda8;
        pass_count = 0;
        fail_count = 0;
        arst_n     = 1'b0;
        in_valid   = 1'b0;
        in_pc      = '0;
        in_inst    = '0;
        #1;
        test_reset();
        test_2ri14();
        test_2ri12_3r();
        test_exceptions();
        test_back_to_back();
        $display("checks passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
loongarch_pkg.sv
id_2ri14.sv
id_2ri12.sv
id_3r.sv
id_dispatch.sv
id_stage.sv
tb_id_stage.sv

// File: run_sim.sh
#!/bin/sh
# build and run the id_stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_id_stage -f vlog.f > build.log 2>&1 \
    && ./obj_dir/Vtb_id_stage > sim.log 2>&1 \
    || echo "TEST RESULT: FAIL" >> sim.log

cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1 || exit 0
